// ==== soc8.f ====
+incdir+src
src/bus_pkg.sv
src/periph_pkg.sv
src/reset_stretch.sv
src/bus_decode.sv
src/bram_wb8.sv
src/timer_wb8.sv
src/prng_wb8.sv
src/gpio_wb8.sv
src/soc8_top.sv
bench/soc8_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run soc8_tb and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

obj_dir/Vsoc8_tb: soc8.f $(wildcard src/*.sv src/*.svh bench/*.sv)
	verilator --binary --timing --timescale 1ns/1ps -f soc8.f --top-module soc8_tb -o Vsoc8_tb

test: obj_dir/Vsoc8_tb
	./obj_dir/Vsoc8_tb > sim.log 2>&1; cat sim.log
	@if grep -q "^Test passed$$" sim.log; then \
		echo "make test: simulation ok"; \
	else \
		echo "make test: simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== bench/soc8_input.txt ====
# name kind addr data expect, all numbers hex
# kind W write, R read, P poll (read & data == expect), G gpio_o, I irq_o, D drive gpio_i
rst_gpio        G 00000000 00 00
rst_irq         I 00000000 00 00
rst_prng_hi     R FFFFFE01 00 00
rst_prng_lo     R FFFFFE00 00 01
ram_wr_a        W 00000010 11 00
ram_wr_b        W 00001FFF 22 00
ram_wr_c        W 12345678 33 00
ram_wr_top      W FFFFFC80 44 00
ram_rd_a        R 00000010 00 11
ram_rd_b        R 00001FFF 00 22
ram_rd_c        R 12345678 00 33
ram_rd_top      R FFFFFC80 00 44
gpio_write      W FFFFFF00 A5 00
gpio_chk_w      G 00000000 00 A5
gpio_set        W FFFFFF01 0F 00
gpio_chk_s      G 00000000 00 AF
gpio_clear      W FFFFFF02 81 00
gpio_chk_c      G 00000000 00 2E
gpio_toggle     W FFFFFF03 FF 00
gpio_chk_t      G 00000000 00 D1
gpio_rd_out     R FFFFFF01 00 D1
gpio_pins       D 00000000 3C 00
gpio_rd_pins    R FFFFFF03 00 3C
prng_seed_lo    W FFFFFE00 E1 00
prng_seed_hi    W FFFFFE01 AC 00
prng_rd_1       R FFFFFE00 00 E1
prng_rd_2       R FFFFFE00 00 70
prng_rd_3       R FFFFFE00 00 38
prng_rd_4       R FFFFFE00 00 9C
prng_rd_hi      R FFFFFE01 00 1C
prng_zero_hi    W FFFFFE01 00 00
prng_zero_lo    W FFFFFE00 00 00
prng_zero_rd_hi R FFFFFE01 00 00
prng_zero_rd_lo R FFFFFE00 00 01
tmr_reload_lo   W FFFFFD00 05 00
tmr_reload_hi   W FFFFFD01 00 00
tmr_irq_idle    I 00000000 00 00
tmr_start       W FFFFFD02 03 00
tmr_wait        P FFFFFD03 01 01
tmr_irq_set     I 00000000 00 01
tmr_stop        W FFFFFD02 02 00
tmr_clear       W FFFFFD03 01 00
tmr_irq_clr     I 00000000 00 00
tmr_status      R FFFFFD03 00 00
iso_ram         W 00001F00 5A 00
iso_gpio        W FFFFFF00 C3 00
iso_ram_rd      R 00001F00 00 5A
iso_gpio_out    G 00000000 00 C3

// ==== bench/soc8_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc8_config.svh"

module soc8_tb;

    localparam int ACK_LIMIT = 8;
    localparam int ACK_LATENCY = 1;
    localparam int RESET_WAIT = `SOC8_RESET_CYCLES + 16;
    localparam int POLL_LIMIT = 100;
    localparam bus_pkg::adr_t GPIO_OUT_ADR = 32'hFFFF_FF00;

    logic           clk;
    logic           rst_n;
    bus_pkg::adr_t  adr;
    bus_pkg::byte_t wdat;
    logic           we;
    logic           stb;
    logic [7:0]     gpio_in;
    bus_pkg::byte_t rdat;
    logic           ack;
    logic           irq;
    logic [7:0]     gpio_out;

    integer seed;
    int     n_tests;
    int     n_run;
    int     n_pass;
    int     n_fail;

    string          names[$];
    string          kinds[$];
    bus_pkg::adr_t  addrs[$];
    bus_pkg::byte_t datas[$];
    bus_pkg::byte_t expects[$];

    soc8_top dut0 (
        .clk     (clk),
        .rst_n_i (rst_n),
        .adr_i   (adr),
        .dat_i   (wdat),
        .we_i    (we),
        .stb_i   (stb),
        .gpio_i  (gpio_in),
        .dat_o   (rdat),
        .ack_o   (ack),
        .irq_o   (irq),
        .gpio_o  (gpio_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic load_tests(output logic ok);
        int            fd;
        int            cnt;
        string         line;
        string         nm;
        string         kd;
        logic [31:0]   a;
        logic [31:0]   d;
        logic [31:0]   e;
        ok = 1'b0;
        fd = $fopen("bench/soc8_input.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    cnt = $sscanf(line, "%s %s %h %h %h", nm, kd, a, d, e);
                    if (cnt == 5) begin
                        names.push_back(nm);
                        kinds.push_back(kd);
                        addrs.push_back(a);
                        datas.push_back(d[7:0]);
                        expects.push_back(e[7:0]);
                    end
                end
            end
            $fclose(fd);
            ok = (names.size() > 0);
        end
    endtask

    // one strobed access held until ack or until limit cycles pass
    task automatic bus_cycle(input bus_pkg::adr_t a, input bus_pkg::byte_t d,
                             input logic w, input int limit,
                             output bus_pkg::byte_t rd, output logic got_ack,
                             output int lat);
        int waited;
        waited = 0;
        got_ack = 1'b0;
        rd = 8'h00;
        lat = 0;
        @(posedge clk);
        adr  <= a;
        wdat <= d;
        we   <= w;
        stb  <= 1'b1;
        while (!got_ack && waited < limit) begin
            @(negedge clk);
            waited++;
            if (ack === 1'b1) begin
                got_ack = 1'b1;
                rd = rdat;
                // cycles from the strobe to ack
                lat = waited - 1;
            end
        end
        @(posedge clk);
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic finish_test(input string name, input logic ok);
        n_run++;
        if (ok) begin
            n_pass++;
            $display("%s: ok", name);
        end else begin
            n_fail++;
            $display("%s: failed", name);
        end
    endtask

    task automatic run_test(input int i);
        bus_pkg::byte_t rd;
        logic           got_ack;
        logic           ok;
        logic           done;
        int             polls;
        int             lat;
        ok = 1'b1;
        done = 1'b0;
        polls = 0;
        if (kinds[i] == "W") begin
            bus_cycle(addrs[i], datas[i], 1'b1, ACK_LIMIT, rd, got_ack, lat);
            if (!got_ack) begin
                $display("%s: write to %h was never acknowledged", names[i], addrs[i]);
                ok = 1'b0;
            end else if (lat != ACK_LATENCY) begin
                $display("%s: ack for %h came %0d cycles after the strobe, not %0d",
                         names[i], addrs[i], lat, ACK_LATENCY);
                ok = 1'b0;
            end
        end else if (kinds[i] == "R") begin
            bus_cycle(addrs[i], 8'h00, 1'b0, ACK_LIMIT, rd, got_ack, lat);
            if (!got_ack) begin
                $display("%s: read from %h was never acknowledged", names[i], addrs[i]);
                ok = 1'b0;
            end else if (lat != ACK_LATENCY) begin
                $display("%s: ack for %h came %0d cycles after the strobe, not %0d",
                         names[i], addrs[i], lat, ACK_LATENCY);
                ok = 1'b0;
            end else if (rd !== expects[i]) begin
                $display("error: %s expected %h actual %h", names[i], expects[i], rd);
                ok = 1'b0;
            end
        end else if (kinds[i] == "P") begin
            while (ok && !done && polls < POLL_LIMIT) begin
                bus_cycle(addrs[i], 8'h00, 1'b0, ACK_LIMIT, rd, got_ack, lat);
                polls++;
                if (!got_ack) begin
                    $display("%s: poll of %h was never acknowledged", names[i], addrs[i]);
                    ok = 1'b0;
                end else if (lat != ACK_LATENCY) begin
                    $display("%s: ack for %h came %0d cycles after the strobe, not %0d",
                             names[i], addrs[i], lat, ACK_LATENCY);
                    ok = 1'b0;
                end else if ((rd & datas[i]) == expects[i]) begin
                    done = 1'b1;
                end
            end
            if (ok && !done) begin
                $display("%s: %h under mask %h never read as %h in %0d polls",
                         names[i], addrs[i], datas[i], expects[i], POLL_LIMIT);
                ok = 1'b0;
            end
        end else if (kinds[i] == "G") begin
            @(negedge clk);
            if (gpio_out !== expects[i]) begin
                $display("error: %s expected %h actual %h", names[i], expects[i], gpio_out);
                ok = 1'b0;
            end
        end else if (kinds[i] == "I") begin
            @(negedge clk);
            if (irq !== expects[i][0]) begin
                $display("%s: irq_o is %b but should be %b", names[i], irq, expects[i][0]);
                ok = 1'b0;
            end
        end else if (kinds[i] == "D") begin
            @(posedge clk);
            gpio_in <= datas[i];
            // let the pins pass the input synchronizer
            repeat (3) @(posedge clk);
        end else begin
            $display("%s: unknown transaction kind %s in the input file", names[i], kinds[i]);
            ok = 1'b0;
        end
        finish_test(names[i], ok);
    endtask

    initial begin
        logic           loaded;
        logic           ok;
        logic           got_ack;
        bus_pkg::byte_t rd;
        int             idle;
        int             lat;
        seed = 14795;
        rst_n = 1'b0;
        adr = '0;
        wdat = '0;
        we = 1'b0;
        stb = 1'b0;
        gpio_in = 8'h00;
        n_run = 0;
        n_pass = 0;
        n_fail = 0;
        load_tests(loaded);
        if (!loaded) begin
            $display("no test could be read from bench/soc8_input.txt");
            n_fail++;
        end else begin
            n_tests = names.size();
            repeat (3) @(posedge clk);
            rst_n <= 1'b1;
            @(negedge clk);
            ok = 1'b1;
            if (ack !== 1'b0 || irq !== 1'b0 || gpio_out !== 8'h00) begin
                $display("reset_state: ack_o, irq_o or gpio_o not low after reset (%b %b %h)",
                         ack, irq, gpio_out);
                ok = 1'b0;
            end
            finish_test("reset_state", ok);
            // first ack marks the end of the reset stretch
            ok = 1'b1;
            bus_cycle(GPIO_OUT_ADR, 8'h00, 1'b0, RESET_WAIT, rd, got_ack, lat);
            if (!got_ack) begin
                $display("reset_release: no ack within %0d cycles of reset release", RESET_WAIT);
                ok = 1'b0;
            end else if (rd !== 8'h00) begin
                $display("error: reset_release expected %h actual %h", 8'h00, rd);
                ok = 1'b0;
            end
            finish_test("reset_release", ok);
            for (int i = 0; i < n_tests; i++) begin
                idle = $random(seed) & 3;
                repeat (idle) @(posedge clk);
                run_test(i);
            end
        end
        $display("tests run %0d, passed %0d, failed %0d", n_run, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (n_tests > 0);
        repeat (n_tests * 2000) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", n_tests * 2000);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/soc8_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc8_config.svh"

module soc8_top (
    input  logic           clk,
    input  logic           rst_n_i,
    input  bus_pkg::adr_t  adr_i,
    input  bus_pkg::byte_t dat_i,
    input  logic           we_i,
    input  logic           stb_i,
    input  logic [7:0]     gpio_i,
    output bus_pkg::byte_t dat_o,
    output logic           ack_o,
    output logic           irq_o,
    output logic [7:0]     gpio_o
);

    logic           sys_rst_n;
    logic           ram_stb;
    logic           timer_stb;
    logic           prng_stb;
    logic           gpio_stb;
    bus_pkg::byte_t ram_dat;
    bus_pkg::byte_t timer_dat;
    bus_pkg::byte_t prng_dat;
    bus_pkg::byte_t gpio_dat;
    logic           ram_ack;
    logic           timer_ack;
    logic           prng_ack;
    logic           gpio_ack;

    reset_stretch rst0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .sys_rst_n_o (sys_rst_n)
    );

    bus_decode dec0 (
        .adr_i       (adr_i),
        .stb_i       (stb_i),
        .ram_stb_o   (ram_stb),
        .timer_stb_o (timer_stb),
        .prng_stb_o  (prng_stb),
        .gpio_stb_o  (gpio_stb),
        .ram_dat_i   (ram_dat),
        .timer_dat_i (timer_dat),
        .prng_dat_i  (prng_dat),
        .gpio_dat_i  (gpio_dat),
        .ram_ack_i   (ram_ack),
        .timer_ack_i (timer_ack),
        .prng_ack_i  (prng_ack),
        .gpio_ack_i  (gpio_ack),
        .dat_o       (dat_o),
        .ack_o       (ack_o)
    );

    bram_wb8 #(
        .ADDR_BITS (`SOC8_RAM_ADDR_BITS)
    ) ram0 (
        .clk     (clk),
        .rst_n_i (sys_rst_n),
        .stb_i   (ram_stb),
        .we_i    (we_i),
        .adr_i   (adr_i[`SOC8_RAM_ADDR_BITS-1:0]),
        .dat_i   (dat_i),
        .dat_o   (ram_dat),
        .ack_o   (ram_ack)
    );

    timer_wb8 tmr0 (
        .clk     (clk),
        .rst_n_i (sys_rst_n),
        .stb_i   (timer_stb),
        .we_i    (we_i),
        .adr_i   (adr_i[1:0]),
        .dat_i   (dat_i),
        .dat_o   (timer_dat),
        .ack_o   (timer_ack),
        .irq_o   (irq_o)
    );

    prng_wb8 prng0 (
        .clk     (clk),
        .rst_n_i (sys_rst_n),
        .stb_i   (prng_stb),
        .we_i    (we_i),
        .adr_i   (adr_i[0]),
        .dat_i   (dat_i),
        .dat_o   (prng_dat),
        .ack_o   (prng_ack)
    );

    gpio_wb8 gpio0 (
        .clk     (clk),
        .rst_n_i (sys_rst_n),
        .stb_i   (gpio_stb),
        .we_i    (we_i),
        .adr_i   (adr_i[1:0]),
        .dat_i   (dat_i),
        .gpio_i  (gpio_i),
        .dat_o   (gpio_dat),
        .ack_o   (gpio_ack),
        .gpio_o  (gpio_o)
    );

endmodule

`default_nettype wire

// ==== src/gpio_wb8.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_wb8 (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           stb_i,
    input  logic           we_i,
    input  logic [1:0]     adr_i,
    input  bus_pkg::byte_t dat_i,
    input  logic [7:0]     gpio_i,
    output bus_pkg::byte_t dat_o,
    output logic           ack_o,
    output logic [7:0]     gpio_o
);

    periph_pkg::gpio_op_e op;
    logic                 req;
    logic [7:0]           in_meta;
    logic [7:0]           in_sync;

    assign op  = periph_pkg::gpio_op_e'(adr_i);
    assign req = stb_i && !ack_o;

    // two-flop synchronizer on the input pins
    always_ff @(posedge clk) begin
        in_meta <= gpio_i;
        in_sync <= in_meta;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_o  <= 1'b0;
            gpio_o <= 8'h00;
        end else begin
            ack_o <= req;
            if (req && we_i) begin
                case (op)
                    periph_pkg::GPIO_WRITE:  gpio_o <= dat_i;
                    periph_pkg::GPIO_SET:    gpio_o <= gpio_o | dat_i;
                    periph_pkg::GPIO_CLEAR:  gpio_o <= gpio_o & ~dat_i;
                    periph_pkg::GPIO_TOGGLE: gpio_o <= gpio_o ^ dat_i;
                endcase
            end
        end
    end

    // toggle offset reads back the pins
    always_ff @(posedge clk) begin
        if (req) begin
            dat_o <= (op == periph_pkg::GPIO_TOGGLE) ? in_sync : gpio_o;
        end
    end

endmodule

`default_nettype wire

// ==== src/prng_wb8.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc8_config.svh"

module prng_wb8 (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           stb_i,
    input  logic           we_i,
    input  logic           adr_i,
    input  bus_pkg::byte_t dat_i,
    output bus_pkg::byte_t dat_o,
    output logic           ack_o
);

    periph_pkg::prng_reg_e reg_sel;
    logic                  req;
    logic [15:0]           state;
    logic [15:0]           seed;

    // galois step, shift right and fold taps on a 1 out
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] fb;
        fb = s[0] ? `SOC8_PRNG_TAPS : 16'h0000;
        return (s >> 1) ^ fb;
    endfunction

    assign reg_sel = periph_pkg::prng_reg_e'(adr_i);
    assign req     = stb_i && !ack_o;

    always_comb begin
        seed = state;
        if (reg_sel == periph_pkg::PRNG_LO) begin
            seed[7:0] = dat_i;
        end else begin
            seed[15:8] = dat_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
            state <= 16'h0001;
        end else begin
            ack_o <= req;
            if (req && we_i) begin
                // all-zero state never leaves zero
                state <= (seed == 16'h0000) ? 16'h0001 : seed;
            end else if (req && reg_sel == periph_pkg::PRNG_LO) begin
                state <= lfsr_step(state);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            dat_o <= (reg_sel == periph_pkg::PRNG_LO) ? state[7:0] : state[15:8];
        end
    end

endmodule

`default_nettype wire

// ==== src/timer_wb8.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc8_config.svh"

module timer_wb8 #(
    parameter int PRESCALE = `SOC8_TIMER_PRESCALE
) (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           stb_i,
    input  logic           we_i,
    input  logic [1:0]     adr_i,
    input  bus_pkg::byte_t dat_i,
    output bus_pkg::byte_t dat_o,
    output logic           ack_o,
    output logic           irq_o
);

    localparam int PW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    periph_pkg::timer_reg_e reg_sel;
    logic                   req;
    logic                   tick;
    logic                   expire;
    logic [PW-1:0]          pre;
    logic [15:0]            reload;
    logic [15:0]            count;
    logic                   run;
    logic                   irq_en;
    logic                   expired;

    assign reg_sel = periph_pkg::timer_reg_e'(adr_i);
    assign req     = stb_i && !ack_o;
    assign tick    = run && (pre == PW'(PRESCALE - 1));
    assign expire  = tick && (count <= 16'd1);
    assign irq_o   = expired && irq_en;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_o   <= 1'b0;
            pre     <= '0;
            reload  <= 16'h0000;
            count   <= 16'h0000;
            run     <= 1'b0;
            irq_en  <= 1'b0;
            expired <= 1'b0;
        end else begin
            ack_o <= req;
            if (run && !tick) begin
                pre <= pre + 1'b1;
            end else begin
                pre <= '0;
            end
            if (expire) begin
                expired <= 1'b1;
                count   <= reload;
            end else if (tick) begin
                count <= count - 1'b1;
            end
            if (req && we_i) begin
                case (reg_sel)
                    periph_pkg::TMR_RELOAD_LO: reload[7:0] <= dat_i;
                    periph_pkg::TMR_RELOAD_HI: reload[15:8] <= dat_i;
                    periph_pkg::TMR_CTRL: begin
                        run    <= dat_i[0];
                        irq_en <= dat_i[1];
                        // restart from reload on run 0 -> 1
                        if (dat_i[0] && !run) begin
                            count <= reload;
                            pre   <= '0;
                        end
                    end
                    periph_pkg::TMR_STATUS: begin
                        // a new expiry wins over the clear
                        if (dat_i[0] && !expire) begin
                            expired <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            case (reg_sel)
                periph_pkg::TMR_RELOAD_LO: dat_o <= reload[7:0];
                periph_pkg::TMR_RELOAD_HI: dat_o <= reload[15:8];
                periph_pkg::TMR_CTRL:      dat_o <= {6'b0, irq_en, run};
                periph_pkg::TMR_STATUS:    dat_o <= {7'b0, expired};
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/bram_wb8.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc8_config.svh"

module bram_wb8 #(
    parameter int ADDR_BITS = `SOC8_RAM_ADDR_BITS
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 stb_i,
    input  logic                 we_i,
    input  logic [ADDR_BITS-1:0] adr_i,
    input  bus_pkg::byte_t       dat_i,
    output bus_pkg::byte_t       dat_o,
    output logic                 ack_o
);

    bus_pkg::byte_t mem [2**ADDR_BITS];

    logic req;

    // strobe stays up through the ack cycle, act only once
    assign req = stb_i && !ack_o;

    always_ff @(posedge clk) begin
        if (req) begin
            if (we_i) begin
                mem[adr_i] <= dat_i;
            end
            dat_o <= mem[adr_i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= req;
        end
    end

endmodule

`default_nettype wire

// ==== src/bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc8_config.svh"

module bus_decode (
    input  bus_pkg::adr_t  adr_i,
    input  logic           stb_i,
    output logic           ram_stb_o,
    output logic           timer_stb_o,
    output logic           prng_stb_o,
    output logic           gpio_stb_o,
    input  bus_pkg::byte_t ram_dat_i,
    input  bus_pkg::byte_t timer_dat_i,
    input  bus_pkg::byte_t prng_dat_i,
    input  bus_pkg::byte_t gpio_dat_i,
    input  logic           ram_ack_i,
    input  logic           timer_ack_i,
    input  logic           prng_ack_i,
    input  logic           gpio_ack_i,
    output bus_pkg::byte_t dat_o,
    output logic           ack_o
);

    bus_pkg::bus_target_e tgt;

    // one 256-byte page per peripheral, RAM gets the rest
    always_comb begin
        case (adr_i[31:8])
            `SOC8_TIMER_PAGE: tgt = bus_pkg::TGT_TIMER;
            `SOC8_PRNG_PAGE:  tgt = bus_pkg::TGT_PRNG;
            `SOC8_GPIO_PAGE:  tgt = bus_pkg::TGT_GPIO;
            default:          tgt = bus_pkg::TGT_RAM;
        endcase
    end

    assign ram_stb_o   = stb_i && (tgt == bus_pkg::TGT_RAM);
    assign timer_stb_o = stb_i && (tgt == bus_pkg::TGT_TIMER);
    assign prng_stb_o  = stb_i && (tgt == bus_pkg::TGT_PRNG);
    assign gpio_stb_o  = stb_i && (tgt == bus_pkg::TGT_GPIO);

    // return path follows the same selection
    always_comb begin
        case (tgt)
            bus_pkg::TGT_TIMER: begin
                dat_o = timer_dat_i;
                ack_o = timer_ack_i;
            end
            bus_pkg::TGT_PRNG: begin
                dat_o = prng_dat_i;
                ack_o = prng_ack_i;
            end
            bus_pkg::TGT_GPIO: begin
                dat_o = gpio_dat_i;
                ack_o = gpio_ack_i;
            end
            default: begin
                dat_o = ram_dat_i;
                ack_o = ram_ack_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/reset_stretch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc8_config.svh"

module reset_stretch (
    input  logic clk,
    input  logic rst_n_i,
    output logic sys_rst_n_o
);

    localparam int CYCLES = `SOC8_RESET_CYCLES;
    localparam int CW = (CYCLES > 1) ? $clog2(CYCLES) : 1;
    localparam logic [CW-1:0] LAST = CW'(CYCLES - 1);

    logic [CW-1:0] cnt;

    // count the released cycles, release on the last one
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cnt <= '0;
            sys_rst_n_o <= 1'b0;
        end else if (cnt == LAST) begin
            sys_rst_n_o <= 1'b1;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

    typedef enum logic [1:0] {
        TMR_RELOAD_LO = 2'd0,
        TMR_RELOAD_HI = 2'd1,
        TMR_CTRL      = 2'd2,
        TMR_STATUS    = 2'd3
    } timer_reg_e;

    typedef enum logic [0:0] {
        PRNG_LO = 1'b0,
        PRNG_HI = 1'b1
    } prng_reg_e;

    // output register ops, selected by address
    typedef enum logic [1:0] {
        GPIO_WRITE  = 2'd0,
        GPIO_SET    = 2'd1,
        GPIO_CLEAR  = 2'd2,
        GPIO_TOGGLE = 2'd3
    } gpio_op_e;

endpackage

`default_nettype wire

// ==== src/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // 8-bit data bus
    typedef logic [7:0] byte_t;

    // full 32-bit master address
    typedef logic [31:0] adr_t;

    // slave picked by the address decoder
    typedef enum logic [1:0] {
        TGT_RAM   = 2'd0,
        TGT_TIMER = 2'd1,
        TGT_PRNG  = 2'd2,
        TGT_GPIO  = 2'd3
    } bus_target_e;

endpackage

`default_nettype wire

// ==== src/soc8_config.svh ====
`ifndef SOC8_CONFIG_SVH
`define SOC8_CONFIG_SVH

// peripheral pages, matched against adr[31:8]
`define SOC8_TIMER_PAGE 24'hFFFFFD
`define SOC8_PRNG_PAGE 24'hFFFFFE
`define SOC8_GPIO_PAGE 24'hFFFFFF

// 8 KB of block RAM behind every other address
`define SOC8_RAM_ADDR_BITS 13

// cycles the internal reset stays low after release
`define SOC8_RESET_CYCLES 16

// clocks per timer count
`define SOC8_TIMER_PRESCALE 4

// galois feedback mask, applied when the outgoing bit is 1
`define SOC8_PRNG_TAPS 16'hB400

`endif
